// ==== build.f ====
+incdir+test
design/jsp_pkg.sv
design/jsp_rx_path.sv
design/jsp_tx_path.sv
design/jsp_core.sv
test/jsp_tb.sv

// ==== Bender.yml ====
package:
  name: jsp_core

sources:
  - design/jsp_pkg.sv
  - design/jsp_rx_path.sv
  - design/jsp_tx_path.sv
  - design/jsp_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/jsp_tb.sv

// ==== test/jsp_tb_tasks.svh ====
/*
 * Scan helpers and directed tests for the JTAG serial port
 *   BIU level and queue setup, capture, byte shift, update
 *   One task per checked behavior
 */

// Levels reach the DUT one edge later, before any capture
task automatic set_levels(input jsp_cnt_t bytes, input jsp_cnt_t space);
  @(posedge tck_i);
  biu_bytes_i <= bytes;
  biu_space_i <= space;
endtask

task automatic load_read_queue(input int n);
  int i;
  @(negedge tck_i);
  rd_queue.delete();
  for (i = 0; i < n; i++) rd_queue.push_back(random_byte());
endtask

task automatic capture_scan();
  @(posedge tck_i);
  select_i     <= 1'b1;
  capture_dr_i <= 1'b1;
  @(posedge tck_i);
  capture_dr_i <= 1'b0;
endtask

// One byte LSB first, tdo sampled mid-cycle; pause_at < 0 means no pause
task automatic shift_byte(input jsp_byte_t din, input int pause_at, output jsp_byte_t dout);
  int i;
  dout = '0;
  for (i = 0; i < byte_w; i++) begin
    if (i == pause_at) begin
      @(posedge tck_i);
      shift_dr_i <= 1'b0;
      tdi_i      <= ~din[i];  // Junk on tdi, must be ignored
      repeat (pause_cycles - 1) @(posedge tck_i);
    end
    @(posedge tck_i);
    shift_dr_i <= 1'b1;
    tdi_i      <= din[i];
    @(negedge tck_i);
    dout[i] = tdo_o;
  end
endtask

// Last bit goes in on the first edge here
task automatic update_scan();
  @(posedge tck_i);
  shift_dr_i  <= 1'b0;
  update_dr_i <= 1'b1;
  @(posedge tck_i);
  update_dr_i <= 1'b0;
  @(negedge tck_i);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic reset_state();
  int i;
  start_test();
  for (i = 0; i < 4; i++) begin
    if (tdo_o !== 1'b0) record_error("tdo_o", 0, tdo_o);
    if (biu_wr_strobe_o !== 1'b0) record_error("biu_wr_strobe_o", 0, biu_wr_strobe_o);
    if (biu_rd_strobe_o !== 1'b0) record_error("biu_rd_strobe_o", 0, biu_rd_strobe_o);
    @(negedge tck_i);
  end
  close_test("reset_state");
endtask

task automatic status_byte_out();
  jsp_byte_t dout;
  start_test();
  set_levels(4'd3, 4'd5);
  capture_scan();
  shift_byte(8'h00, -1, dout);
  update_scan();
  if (dout !== {4'd3, 4'd5}) record_error("tdo_o status byte", {4'd3, 4'd5}, dout);
  close_test("status_byte_out");
endtask

// Header then three data bytes, writes limited by user count and space
task automatic write_scan(input jsp_cnt_t space, input jsp_cnt_t user, input string name);
  jsp_byte_t data [3];
  jsp_byte_t dout;
  int        n_exp;
  int        i;
  start_test();
  set_levels(4'd0, space);
  for (i = 0; i < 3; i++) data[i] = random_byte();
  n_exp = 3;
  if (user < n_exp) n_exp = user;
  if (space < n_exp) n_exp = space;
  capture_scan();
  shift_byte({user, 4'hc}, -1, dout);  // Low nibble of header unused
  for (i = 0; i < 3; i++) shift_byte(data[i], -1, dout);
  update_scan();
  if (wr_strobes != n_exp) record_error("biu_wr_strobe_o pulses", n_exp, wr_strobes);
  for (i = 0; i < n_exp && i < wr_log.size(); i++) begin
    if (wr_log[i] !== data[i]) record_error("biu_data_o", data[i], wr_log[i]);
  end
  close_test(name);
endtask

task automatic write_transfer();
  write_scan(4'd5, 4'd2, "write_transfer");
endtask

task automatic write_space_limit();
  write_scan(4'd1, 4'd3, "write_space_limit");
endtask

task automatic read_transfer();
  jsp_byte_t exp_data [2];
  jsp_byte_t dout;
  int        i;
  start_test();
  load_read_queue(4);
  exp_data[0] = rd_queue[0];
  exp_data[1] = rd_queue[1];
  set_levels(4'd2, 4'd0);
  capture_scan();
  shift_byte(8'h00, -1, dout);
  if (dout !== {4'd2, 4'd0}) record_error("tdo_o status byte", {4'd2, 4'd0}, dout);
  for (i = 0; i < 3; i++) begin
    shift_byte(8'h00, -1, dout);  // Third byte lies past the count
    if (i < 2 && dout !== exp_data[i]) record_error("tdo_o data byte", exp_data[i], dout);
  end
  update_scan();
  if (rd_strobes != 2) record_error("biu_rd_strobe_o pulses", 2, rd_strobes);
  close_test("read_transfer");
endtask

// Counts are left nonzero at update, so a missed update would strobe again
task automatic pause_then_update();
  jsp_byte_t   din;
  jsp_byte_t   dout;
  jsp_byte_t   exp_rd;
  logic [31:0] rnd;
  int          i;
  start_test();
  load_read_queue(2);
  exp_rd = rd_queue[0];
  din    = random_byte();
  set_levels(4'd2, 4'd2);
  capture_scan();
  shift_byte(8'h30, -1, dout);  // User count 3
  shift_byte(din, 3, dout);     // Paused after bit 2
  update_scan();
  if (dout !== exp_rd) record_error("tdo_o data byte", exp_rd, dout);
  if (rd_strobes != 1) record_error("biu_rd_strobe_o pulses", 1, rd_strobes);
  if (wr_log.size() != 1) begin
    record_error("biu_wr_strobe_o pulses", 1, wr_log.size());
  end else if (wr_log[0] !== din) begin
    record_error("biu_data_o", din, wr_log[0]);
  end
  // Shifting after update, FSMs must stay idle
  for (i = 0; i < 12; i++) begin
    rnd = $random(seed);
    @(posedge tck_i);
    shift_dr_i <= 1'b1;
    tdi_i      <= rnd[0];
  end
  @(posedge tck_i);
  shift_dr_i <= 1'b0;
  @(negedge tck_i);
  if (wr_strobes != 1) record_error("biu_wr_strobe_o pulses after update", 1, wr_strobes);
  if (rd_strobes != 1) record_error("biu_rd_strobe_o pulses after update", 1, rd_strobes);
  close_test("pause_then_update");
endtask

// ==== test/jsp_tb.sv ====
/*
 * JTAG serial port core testbench
 *   Clock, reset and DUT instance
 *   Data register model and BIU byte FIFO model
 *   Error bookkeeping, watchdog, test sequence and final report
 */

`timescale 1ns/100ps
`default_nettype none

module jsp_tb;

  import jsp_pkg::*;

  localparam int clk_period_ns   = 8;
  localparam int cycles_per_test = 200;
  localparam int num_tests       = 6;
  localparam int watchdog_ns     = clk_period_ns * cycles_per_test * num_tests;
  localparam int pause_cycles    = 5;  // shift_dr low inside a byte

  // DUT signals
  logic                       tck_i;
  logic                       rst_i;
  logic                       tdi_i;
  logic                       tdo_o;
  logic                       select_i;
  logic                       capture_dr_i;
  logic                       shift_dr_i;
  logic                       update_dr_i;
  logic [jsp_datareg_len-1:0] data_register_i;
  jsp_byte_t                  biu_data_o;
  jsp_byte_t                  biu_data_i;
  jsp_cnt_t                   biu_bytes_i;
  jsp_cnt_t                   biu_space_i;
  logic                       biu_wr_strobe_o;
  logic                       biu_rd_strobe_o;

  // BIU model
  jsp_byte_t rd_queue[$];  // Bytes for the host, head sits on biu_data_i
  jsp_byte_t wr_log[$];    // Bytes taken by write strobes
  int        wr_strobes;
  int        rd_strobes;

  // Bookkeeping
  integer seed;
  int     err_cnt;
  int     test_errs;     // err_cnt at start of current test
  int     tests_run;
  int     tests_failed;

  jsp_core jsp_core_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .tdo_o           (tdo_o),
    .select_i        (select_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .data_register_i (data_register_i),
    .biu_data_o      (biu_data_o),
    .biu_data_i      (biu_data_i),
    .biu_bytes_i     (biu_bytes_i),
    .biu_space_i     (biu_space_i),
    .biu_wr_strobe_o (biu_wr_strobe_o),
    .biu_rd_strobe_o (biu_rd_strobe_o)
  );

  initial begin
    tck_i = 1'b0;
    forever #(clk_period_ns / 2) tck_i = ~tck_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Models
  ////////////////////////////////////////////////////////////////////////////

  // Shared data register, tdi enters the MSB
  always @(posedge tck_i) begin
    if (shift_dr_i) data_register_i <= {tdi_i, data_register_i[jsp_datareg_len-1:1]};
  end

  // BIU write side, latch at the strobe edge
  always @(posedge tck_i) begin
    if (biu_wr_strobe_o) begin
      wr_log.push_back(biu_data_o);
      wr_strobes++;
    end
  end

  // BIU read side, pop on strobe and present the next head
  always @(posedge tck_i) begin
    if (biu_rd_strobe_o) begin
      rd_strobes++;
      if (rd_queue.size() != 0) void'(rd_queue.pop_front());
    end
    biu_data_i <= (rd_queue.size() != 0) ? rd_queue[0] : '0;  // Empty FIFO reads zero
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bookkeeping helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic jsp_byte_t random_byte();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[byte_w-1:0];
  endfunction

  task automatic record_error(input string sig, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("ERR %s: expected 0x%0h, got 0x%0h", sig, expected, actual);
    err_cnt++;
  endtask

  // Mid-cycle, so no strobe edge is in flight
  task automatic start_test();
    @(negedge tck_i);
    test_errs  = err_cnt;
    wr_strobes = 0;
    rd_strobes = 0;
    wr_log.delete();
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (err_cnt == test_errs) begin
      $display("%-18s passed", name);
    end else begin
      tests_failed++;
      $display("%-18s failed, %0d errors", name, err_cnt - test_errs);
    end
  endtask

  `include "jsp_tb_tasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed            = 2371;
    err_cnt         = 0;
    tests_run       = 0;
    tests_failed    = 0;
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    select_i        = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    data_register_i = '0;
    biu_data_i      = '0;
    biu_bytes_i     = '0;
    biu_space_i     = '0;
    repeat (3) @(posedge tck_i);
    rst_i <= 1'b0;

    reset_state();
    status_byte_out();
    write_transfer();
    write_space_limit();
    read_transfer();
    pause_then_update();

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Watchdog: tests still running after %0d ns, run stopped", watchdog_ns);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/jsp_core.sv ====
/*
 * JTAG serial port core, top level
 *   Bundles TAP and BIU status signals into structs
 *   Write path and read path instances
 */

`timescale 1ns/100ps
`default_nettype none

module jsp_core (
  input  wire logic                                tck_i,
  input  wire logic                                rst_i,
  input  wire logic                                tdi_i,
  output logic                                     tdo_o,

  // TAP controller
  input  wire logic                                select_i,
  input  wire logic                                capture_dr_i,
  input  wire logic                                shift_dr_i,
  input  wire logic                                update_dr_i,
  input  wire logic [jsp_pkg::jsp_datareg_len-1:0] data_register_i,  // Kept outside the core

  // BIU byte FIFO
  output jsp_pkg::jsp_byte_t                       biu_data_o,       // Host to BIU
  input  wire jsp_pkg::jsp_byte_t                  biu_data_i,       // BIU to host
  input  wire jsp_pkg::jsp_cnt_t                   biu_bytes_i,
  input  wire jsp_pkg::jsp_cnt_t                   biu_space_i,
  output logic                                     biu_wr_strobe_o,
  output logic                                     biu_rd_strobe_o
);

  import jsp_pkg::*;

  tap_ctrl_t   tap;     // TAP state for both paths
  biu_status_t status;  // Fill levels, also the status byte

  assign tap    = '{select: select_i, capture_dr: capture_dr_i,
                    shift_dr: shift_dr_i, update_dr: update_dr_i};
  assign status = '{bytes_avail: biu_bytes_i, space_free: biu_space_i};

  // Host to BIU
  jsp_rx_path jsp_rx_path_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tap_i           (tap),
    .status_i        (status),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .biu_data_o      (biu_data_o),
    .biu_wr_strobe_o (biu_wr_strobe_o)
  );

  // BIU to host
  jsp_tx_path jsp_tx_path_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tap_i           (tap),
    .status_i        (status),
    .biu_data_i      (biu_data_i),
    .tdo_o           (tdo_o),
    .biu_rd_strobe_o (biu_rd_strobe_o)
  );

endmodule

`default_nettype wire

// ==== design/jsp_tx_path.sv ====
/*
 * JTAG serial port read path (BIU to host)
 *   Read FSM, read bit counter, available byte counter
 *   Output shift register driving tdo, BIU read strobe
 */

`timescale 1ns/100ps
`default_nettype none

module jsp_tx_path (
  input  wire logic                 tck_i,
  input  wire logic                 rst_i,
  input  wire jsp_pkg::tap_ctrl_t   tap_i,
  input  wire jsp_pkg::biu_status_t status_i,
  input  wire jsp_pkg::jsp_byte_t   biu_data_i,
  output logic                      tdo_o,
  output logic                      biu_rd_strobe_o
);

  import jsp_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  tx_state_e            state_q, state_d;
  logic [bit_cnt_w-1:0] bit_cnt_q;    // Bits of the current byte shifted out
  jsp_cnt_t             avail_cnt_q;  // BIU bytes left to fetch this scan
  jsp_byte_t            out_sreg_q;   // Parallel load, shifts right into tdo

  // Controls from the FSM
  logic bit_cnt_en;
  logic bit_cnt_clr;
  logic avail_cnt_ld;
  logic avail_cnt_dec;
  logic out_ld_status;  // Load the status byte
  logic out_ld_biu;     // Load the BIU head byte
  logic out_shift;

  // Status
  logic scan_start;
  logic bit_cnt_max;
  logic avail_zero;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign scan_start  = tap_i.select & tap_i.capture_dr;
  assign bit_cnt_max = &bit_cnt_q;
  assign avail_zero  = ~|avail_cnt_q;
  assign tdo_o       = out_sreg_q[0];  // LSB first

  // Bit counter, wraps after each byte
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_clr) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_en) begin
      bit_cnt_q <= bit_cnt_q + bit_cnt_w'(1);
    end
  end

  // Available byte counter
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      avail_cnt_q <= '0;
    end else if (avail_cnt_ld) begin
      avail_cnt_q <= status_i.bytes_avail;
    end else if (avail_cnt_dec) begin
      avail_cnt_q <= avail_cnt_q - jsp_cnt_t'(1);
    end
  end

  // Output shift register, a load takes the place of the shift
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_sreg_q <= '0;
    end else if (out_ld_status) begin
      out_sreg_q <= status_i;  // Struct layout is the status byte
    end else if (out_ld_biu) begin
      out_sreg_q <= biu_data_i;
    end else if (out_shift) begin
      out_sreg_q <= {1'b0, out_sreg_q[byte_w-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= TX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state, RDACK covers one bit and XFER the other seven
  always_comb begin
    state_d = state_q;
    case (state_q)
      TX_IDLE: begin
        if (scan_start) state_d = TX_COUNTS;
      end
      TX_COUNTS, TX_XFER: begin
        if (tap_i.update_dr) begin
          state_d = TX_IDLE;
        end else if (tap_i.shift_dr && bit_cnt_max) begin
          state_d = TX_RDACK;  // Next byte starts
        end
      end
      TX_RDACK: begin
        if (tap_i.update_dr) begin
          state_d = TX_IDLE;
        end else if (tap_i.shift_dr) begin
          state_d = TX_XFER;
        end
      end
      default: state_d = TX_IDLE;
    endcase
  end

  // Outputs
  always_comb begin
    bit_cnt_en      = 1'b0;
    bit_cnt_clr     = 1'b0;
    avail_cnt_ld    = 1'b0;
    avail_cnt_dec   = 1'b0;
    out_ld_status   = 1'b0;
    out_ld_biu      = 1'b0;
    out_shift       = 1'b0;
    biu_rd_strobe_o = 1'b0;
    case (state_q)
      TX_IDLE: begin
        if (scan_start) begin
          bit_cnt_clr   = 1'b1;
          avail_cnt_ld  = 1'b1;
          out_ld_status = 1'b1;  // Status goes out first
        end
      end
      TX_COUNTS: begin
        if (tap_i.shift_dr) begin
          bit_cnt_en = 1'b1;
          out_shift  = 1'b1;
          // Fetch the first data byte, ack comes in RDACK
          if (bit_cnt_max && !avail_zero) out_ld_biu = 1'b1;
        end
      end
      TX_RDACK: begin
        if (tap_i.shift_dr) begin
          bit_cnt_en      = 1'b1;
          out_shift       = 1'b1;
          biu_rd_strobe_o = !avail_zero;  // BIU pops the byte just loaded
        end
      end
      TX_XFER: begin
        if (tap_i.shift_dr) begin
          bit_cnt_en = 1'b1;
          out_shift  = 1'b1;
          if (bit_cnt_max && !avail_zero) begin
            out_ld_biu    = 1'b1;
            avail_cnt_dec = 1'b1;  // One byte fully sent
          end
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/jsp_rx_path.sv ====
/*
 * JTAG serial port write path (host to BIU)
 *   Write FSM, write bit counter, space and user byte counters
 *   Combinational BIU write strobe and write data
 */

`timescale 1ns/100ps
`default_nettype none

module jsp_rx_path (
  input  wire logic                                tck_i,
  input  wire logic                                rst_i,
  input  wire jsp_pkg::tap_ctrl_t                  tap_i,
  input  wire jsp_pkg::biu_status_t                status_i,
  input  wire logic                                tdi_i,
  input  wire logic [jsp_pkg::jsp_datareg_len-1:0] data_register_i,
  output jsp_pkg::jsp_byte_t                       biu_data_o,
  output logic                                     biu_wr_strobe_o
);

  import jsp_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  rx_state_e            state_q, state_d;
  logic [bit_cnt_w-1:0] bit_cnt_q;    // Bits of the current byte shifted in
  jsp_cnt_t             space_cnt_q;  // BIU free space left this scan
  jsp_cnt_t             user_cnt_q;   // Bytes the host still intends to send
  jsp_cnt_t             user_cnt_in;  // Header high nibble

  // Counter controls from the FSM
  logic bit_cnt_en;
  logic bit_cnt_clr;
  logic space_cnt_ld;
  logic space_cnt_dec;
  logic user_cnt_ld;
  logic user_cnt_dec;

  // Status
  logic scan_start;
  logic bit_cnt_max;
  logic space_zero;
  logic user_zero;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign scan_start  = tap_i.select & tap_i.capture_dr;
  assign bit_cnt_max = &bit_cnt_q;        // Eighth bit on tdi this cycle
  assign space_zero  = ~|space_cnt_q;
  assign user_zero   = ~|user_cnt_q;

  // The register holds the seven earlier bits, tdi carries the last one
  assign user_cnt_in = {tdi_i, data_register_i[jsp_datareg_len-1 -: cnt_w-1]};
  assign biu_data_o  = {tdi_i, data_register_i[jsp_datareg_len-1 -: byte_w-1]};

  // Bit counter, wraps to zero after the eighth bit
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_clr) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_en) begin
      bit_cnt_q <= bit_cnt_q + bit_cnt_w'(1);
    end
  end

  // Space counter, loaded from the BIU at capture
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      space_cnt_q <= '0;
    end else if (space_cnt_ld) begin
      space_cnt_q <= status_i.space_free;
    end else if (space_cnt_dec) begin
      space_cnt_q <= space_cnt_q - jsp_cnt_t'(1);
    end
  end

  // User counter, loaded from the header byte
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      user_cnt_q <= '0;
    end else if (user_cnt_ld) begin
      user_cnt_q <= user_cnt_in;
    end else if (user_cnt_dec) begin
      user_cnt_q <= user_cnt_q - jsp_cnt_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= RX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_IDLE: begin
        if (scan_start) state_d = RX_COUNTS;
      end
      RX_COUNTS: begin
        if (tap_i.update_dr) begin
          state_d = RX_IDLE;
        end else if (tap_i.shift_dr && bit_cnt_max) begin
          state_d = RX_XFER;  // Header done
        end
      end
      RX_XFER: begin
        if (tap_i.update_dr) state_d = RX_IDLE;
      end
      default: state_d = RX_IDLE;
    endcase
  end

  // Outputs, nothing moves while shift_dr is low (pause and exit states)
  always_comb begin
    bit_cnt_en      = 1'b0;
    bit_cnt_clr     = 1'b0;
    space_cnt_ld    = 1'b0;
    space_cnt_dec   = 1'b0;
    user_cnt_ld     = 1'b0;
    user_cnt_dec    = 1'b0;
    biu_wr_strobe_o = 1'b0;
    case (state_q)
      RX_IDLE: begin
        if (scan_start) begin
          bit_cnt_clr  = 1'b1;
          space_cnt_ld = 1'b1;  // Snapshot of BIU space for this scan
        end
      end
      RX_COUNTS: begin
        if (tap_i.shift_dr) begin
          bit_cnt_en  = 1'b1;
          user_cnt_ld = bit_cnt_max;
        end
      end
      RX_XFER: begin
        if (tap_i.shift_dr) begin
          bit_cnt_en = 1'b1;
          // Byte complete, hand it over only if both sides allow it
          if (bit_cnt_max && !space_zero && !user_zero) begin
            biu_wr_strobe_o = 1'b1;
            space_cnt_dec   = 1'b1;
            user_cnt_dec    = 1'b1;
          end
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/jsp_pkg.sv ====
/*
 * JTAG serial port shared definitions
 *   Data register, byte, count and bit counter widths
 *   TAP control and BIU fill status structs
 *   Write path and read path FSM state encodings
 */

`default_nettype none

package jsp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned jsp_datareg_len = 64;  // Debug data register, shared at top level
  localparam int unsigned byte_w          = 8;   // One transferred byte
  localparam int unsigned cnt_w           = 4;   // Byte count nibble
  localparam int unsigned bit_cnt_w       = 3;   // Counts 8 bits per byte, wraps

  typedef logic [byte_w-1:0] jsp_byte_t;
  typedef logic [cnt_w-1:0]  jsp_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  // TAP controller signals seen by this module
  typedef struct packed {
    logic select;      // Module selected in the debug chain
    logic capture_dr;  // Capture-DR, starts a scan
    logic shift_dr;    // Shift-DR, one bit per edge
    logic update_dr;   // Update-DR, ends a scan
  } tap_ctrl_t;

  // BIU fill levels, laid out so the struct is the status byte as shifted out
  typedef struct packed {
    jsp_cnt_t bytes_avail;  // High nibble, bytes waiting for the host
    jsp_cnt_t space_free;   // Low nibble, free FIFO slots for host data
  } biu_status_t;

  ////////////////////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////////////////////

  // Write path, host to BIU
  typedef enum logic [1:0] {
    RX_IDLE   = 2'b11,  // Waiting for capture
    RX_COUNTS = 2'b01,  // Shifting in the header byte
    RX_XFER   = 2'b00   // Shifting in data bytes
  } rx_state_e;

  // Read path, BIU to host
  typedef enum logic [1:0] {
    TX_IDLE   = 2'b11,  // Waiting for capture
    TX_COUNTS = 2'b10,  // Shifting out the status byte
    TX_RDACK  = 2'b01,  // First bit of a data byte, acks the BIU
    TX_XFER   = 2'b00   // Remaining seven bits of a data byte
  } tx_state_e;

endpackage

`default_nettype wire
